/* verif/bp_cases.txt */
// op pc target taken_or_ctr pred_taken pred_target exp_flags exp_pc
// op 0 preload (word 3 is the counter), 1 resolve, 2 fetch (flags hit,taken), f ends
// cleared table, every fetch misses
2 00001040 00000000 0 0 00000000 0 00001044
2 00003100 00000000 0 0 00000000 0 00003104
2 00000000 00000000 0 0 00000000 0 00000004
2 fffffffc 00000000 0 0 00000000 0 00000000
// taken miss allocates weakly taken
1 00001040 00002000 1 0 00000000 1 00002000
2 00001040 00000000 0 0 00000000 3 00002000
2 00005040 00000000 0 0 00000000 0 00005044
// two not taken, then one taken is not enough
1 00001040 00002000 0 1 00002000 1 00001044
1 00001040 00002000 0 0 00000000 0 00000000
2 00001040 00000000 0 0 00000000 2 00001044
1 00001040 00002000 1 0 00000000 1 00002000
2 00001040 00000000 0 0 00000000 2 00001044
1 00001040 00002400 1 0 00000000 1 00002400
2 00001040 00000000 0 0 00000000 3 00002400
// saturate at strongly taken
1 00001040 00002400 1 1 00002400 0 00000000
1 00001040 00002400 1 1 00002400 0 00000000
1 00001040 00002400 0 1 00002400 1 00001044
2 00001040 00000000 0 0 00000000 3 00002400
// wrong target mispredicts
1 00001040 00002800 1 1 00002400 1 00002800
2 00001040 00000000 0 0 00000000 3 00002800
// not taken misses write nothing
1 00003100 00000800 0 0 00000000 0 00000000
2 00003100 00000000 0 0 00000000 0 00003104
1 00003100 00000800 0 1 00000800 1 00003104
2 00003100 00000000 0 0 00000000 0 00003104
// preloads and aliases
0 00400200 00401000 3 0 00000000 0 00000000
2 00400200 00000000 0 0 00000000 3 00401000
0 00000a04 00000f00 1 0 00000000 0 00000000
2 00000a04 00000000 0 0 00000000 2 00000a08
2 00800200 00000000 0 0 00000000 0 00800204
0 00005040 00006000 2 0 00000000 0 00000000
2 00005040 00000000 0 0 00000000 3 00006000
2 00001040 00000000 0 0 00000000 0 00001044
1 00005040 00006000 1 1 00006000 0 00000000
2 00005040 00000000 0 0 00000000 3 00006000
f 00000000 00000000 0 0 00000000 0 00000000

/* filelist.f */
hw/bp_pkg.sv
hw/btb_table.sv
hw/btb_arbiter.sv
hw/btb_preload.sv
hw/btb_update.sv
hw/btb_fetch_predict.sv
hw/branch_predictor_top.sv
verif/branch_predictor_assert.sv
verif/tb_branch_predictor.sv

/* run_sim.sh */
#!/bin/sh
# build the branch predictor testbench with Verilator and run it
# the exit status is nonzero when the build or the run fails

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module tb_branch_predictor \
  -o vsim &&
./obj_dir/vsim || exit 1

/* verif/tb_branch_predictor.sv */
/* branch predictor testbench
   replays operation records from the cases file, checks predictions and redirects */

`timescale 1ns/10ps

module tb_branch_predictor;

  logic                        clk_i = 1'b0;
  logic                        rst_i;
  logic                        init_valid;
  logic [bp_pkg::index_w-1:0]  init_addr;
  logic [bp_pkg::entry_w-1:0]  init_entry;
  logic                        fetch_valid;
  logic [bp_pkg::pc_w-1:0]     pc;
  logic                        resolve_valid;
  logic [bp_pkg::pc_w-1:0]     mem_pc;
  logic                        resolve_taken;
  logic [bp_pkg::pc_w-1:0]     resolve_target;
  logic                        pred_taken_in;
  logic [bp_pkg::pc_w-1:0]     pred_target_in;
  logic                        preload_busy;
  logic                        update_busy;
  logic                        fetch_stall;
  logic                        pred_valid;
  logic                        hit;
  logic                        pred_taken;
  logic [bp_pkg::pc_w-1:0]     next_pc;
  logic                        redirect_valid;
  logic [bp_pkg::pc_w-1:0]     redirect_pc;

  logic [31:0] case_mem [0:511];    // 8 words per record, up to 64 records
  int          num_recs;
  int          cycle_count = 0;
  int          cycle_limit = 1000;  // replaced once the records are counted

  branch_predictor_top i_dut (
    .clk_i(clk_i), .rst_i(rst_i), .init_valid(init_valid), .init_addr(init_addr),
    .init_entry(init_entry), .fetch_valid(fetch_valid), .pc(pc),
    .resolve_valid(resolve_valid), .mem_pc(mem_pc), .resolve_taken(resolve_taken),
    .resolve_target(resolve_target), .pred_taken_in(pred_taken_in),
    .pred_target_in(pred_target_in), .preload_busy(preload_busy),
    .update_busy(update_busy), .fetch_stall(fetch_stall), .pred_valid(pred_valid),
    .hit(hit), .pred_taken(pred_taken), .next_pc(next_pc),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc));

  always #4 clk_i = ~clk_i;         // 8 ns period

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout at %0t ns: run did not finish within %0d cycles", $time, cycle_limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_ctr_pred(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %0b, expected %0b", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_addr(input string name, input logic [bp_pkg::pc_w-1:0] got,
                            input logic [bp_pkg::pc_w-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "pc mismatch");
    end
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    while (preload_busy || update_busy) begin
      @(negedge clk_i);             // sweep or update still owns the port
    end
  endtask

  task automatic preload_entry(input logic [31:0] epc, input logic [31:0] tgt,
                               input bp_pkg::ctr_e ctr);
    @(posedge clk_i);
    init_valid <= 1'b1;
    init_addr  <= epc[bp_pkg::index_w+1:2];
    init_entry <= {1'b1, epc[bp_pkg::pc_w-1 -: bp_pkg::tag_w], tgt[31:2], ctr};
    @(posedge clk_i);
    init_valid <= 1'b0;             // single strobe
  endtask

  task automatic resolve_branch(input logic [31:0] rec [8]);
    @(posedge clk_i);
    resolve_valid  <= 1'b1;
    mem_pc         <= rec[1];
    resolve_target <= rec[2];
    resolve_taken  <= rec[3][0];
    pred_taken_in  <= rec[4][0];
    pred_target_in <= rec[5];
    fetch_valid    <= 1'b1;         // lookup of the same pc lands with the redirect
    pc             <= rec[1];
    @(posedge clk_i);
    resolve_valid  <= 1'b0;
    fetch_valid    <= 1'b0;
    @(negedge clk_i);               // one cycle after the strobe
    check_ctr_pred("update_busy", update_busy, 1'b1);
    check_ctr_pred("pred_valid", pred_valid, 1'b1);
    check_ctr_pred("redirect_valid", redirect_valid, rec[6][0]);
    if (rec[6][0]) begin
      check_addr("redirect_pc", redirect_pc, rec[7]);
      check_addr("next_pc", next_pc, rec[7]);      // redirect beats prediction
      check_ctr_pred("pred_taken", pred_taken, 1'b0);
    end
  endtask

  task automatic fetch_lookup(input logic [31:0] rec [8]);
    @(posedge clk_i);
    fetch_valid <= 1'b1;
    pc          <= rec[1];
    @(negedge clk_i);
    while (fetch_stall) begin
      @(negedge clk_i);             // hold pc until the lookup wins
    end
    @(posedge clk_i);
    fetch_valid <= 1'b0;
    @(negedge clk_i);
    while (!pred_valid) begin
      @(negedge clk_i);
    end
    check_ctr_pred("hit", hit, rec[6][1]);
    check_ctr_pred("pred_taken", pred_taken, rec[6][0]);
    check_addr("next_pc", next_pc, rec[7]);
  endtask

  initial begin
    int          r;
    logic [31:0] rec [8];
    rst_i          = 1'b1;
    init_valid     = 1'b0;
    init_addr      = '0;
    init_entry     = '0;
    fetch_valid    = 1'b0;
    pc             = '0;
    resolve_valid  = 1'b0;
    mem_pc         = '0;
    resolve_taken  = 1'b0;
    resolve_target = '0;
    pred_taken_in  = 1'b0;
    pred_target_in = '0;
    void'($urandom(84262));         // seeds the gap generator
    $readmemh("verif/bp_cases.txt", case_mem);
    num_recs = 0;
    while (num_recs < 64 && case_mem[num_recs*8] != 32'hf) begin
      num_recs++;                   // op f ends the list
    end
    if (num_recs == 0) begin
      $display("No records found in the cases file");
      $display("TEST RESULT: FAIL");
      $fatal(1, "empty cases file");
    end
    cycle_limit = 256 + 20 * num_recs;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);               // state right after reset
    check_ctr_pred("preload_busy", preload_busy, 1'b1);
    check_ctr_pred("pred_valid", pred_valid, 1'b0);
    check_ctr_pred("hit", hit, 1'b0);
    check_ctr_pred("pred_taken", pred_taken, 1'b0);
    check_ctr_pred("redirect_valid", redirect_valid, 1'b0);
    check_ctr_pred("fetch_stall", fetch_stall, 1'b0);
    for (r = 0; r < num_recs; r++) begin
      for (int w = 0; w < 8; w++) begin
        rec[w] = case_mem[r*8 + w];
      end
      wait_idle();
      repeat ($urandom % 4) @(posedge clk_i);    // idle gap
      case (rec[0])
        32'd0: preload_entry(rec[1], rec[2], bp_pkg::ctr_e'(rec[3][1:0]));
        32'd1: resolve_branch(rec);
        32'd2: fetch_lookup(rec);
        default: begin
          $display("Record %0d has an unknown op code %h", r, rec[0]);
          $display("TEST RESULT: FAIL");
          $fatal(1, "bad record");
        end
      endcase
    end
    wait_idle();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* verif/branch_predictor_assert.sv */
/* branch predictor assertions
   port arbitration and resolve busy rules, bound into the top level */

`timescale 1ns/10ps

module branch_predictor_assert (
  input logic            clk_i,
  input logic            rst_i,
  input bp_pkg::grant_e  grant,
  input logic            preload_req,
  input logic            update_req,
  input logic            lookup_req,
  input logic            resolve_valid,
  input logic            update_busy,
  input logic            redirect_valid
);

  // grant goes to the highest requester only, and only to a requester
  function automatic logic check_grant(input bp_pkg::grant_e g, input logic p,
                                       input logic u, input logic l);
    bp_pkg::grant_e want;
    if (p) begin
      want = bp_pkg::grant_preload;
    end else if (u) begin
      want = bp_pkg::grant_update;
    end else if (l) begin
      want = bp_pkg::grant_lookup;
    end else begin
      want = bp_pkg::grant_none;
    end
    return g == want;
  endfunction

  a_single_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    check_grant(grant, preload_req, update_req, lookup_req))
    else $error("grant does not match the fixed priority");

  a_no_strobe_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    resolve_valid |-> !update_busy)
    else $error("resolve strobe while update busy");

  a_redirect_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    redirect_valid |=> !redirect_valid)
    else $error("redirect held for two cycles");

endmodule

bind branch_predictor_top branch_predictor_assert i_bp_assert (
  .clk_i(clk_i), .rst_i(rst_i), .grant(grant), .preload_req(preload_req),
  .update_req(update_req), .lookup_req(lookup_req),
  .resolve_valid(resolve_valid), .update_busy(update_busy),
  .redirect_valid(redirect_valid));

/* hw/branch_predictor_top.sv */
/* branch predictor top
   btb table shared by preload, update and lookup through one arbiter */

`timescale 1ns/10ps

module branch_predictor_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        init_valid,
  input  logic [bp_pkg::index_w-1:0]  init_addr,
  input  logic [bp_pkg::entry_w-1:0]  init_entry,
  input  logic                        fetch_valid,
  input  logic [bp_pkg::pc_w-1:0]     pc,
  input  logic                        resolve_valid,
  input  logic [bp_pkg::pc_w-1:0]     mem_pc,
  input  logic                        resolve_taken,
  input  logic [bp_pkg::pc_w-1:0]     resolve_target,
  input  logic                        pred_taken_in,     // prediction carried with the branch
  input  logic [bp_pkg::pc_w-1:0]     pred_target_in,
  output logic                        preload_busy,
  output logic                        update_busy,
  output logic                        fetch_stall,
  output logic                        pred_valid,
  output logic                        hit,
  output logic                        pred_taken,
  output logic [bp_pkg::pc_w-1:0]     next_pc,
  output logic                        redirect_valid,
  output logic [bp_pkg::pc_w-1:0]     redirect_pc
);

  bp_pkg::grant_e              grant;
  logic                        preload_req, preload_we;
  logic [bp_pkg::index_w-1:0]  preload_addr;
  logic [bp_pkg::entry_w-1:0]  preload_wdata;
  logic                        update_req, update_we;
  logic [bp_pkg::index_w-1:0]  update_addr;
  logic [bp_pkg::entry_w-1:0]  update_wdata;
  logic                        lookup_req;
  logic [bp_pkg::index_w-1:0]  lookup_addr;
  logic                        tbl_en, tbl_we;
  logic [bp_pkg::index_w-1:0]  tbl_addr;
  logic [bp_pkg::entry_w-1:0]  tbl_wdata, tbl_rdata;

  btb_table i_table (.clk_i(clk_i), .en(tbl_en), .we(tbl_we), .addr(tbl_addr),
                     .wdata(tbl_wdata), .rdata(tbl_rdata));

  btb_arbiter i_arbiter (
    .preload_req(preload_req), .preload_we(preload_we), .preload_addr(preload_addr),
    .preload_wdata(preload_wdata), .update_req(update_req), .update_we(update_we),
    .update_addr(update_addr), .update_wdata(update_wdata), .lookup_req(lookup_req),
    .lookup_addr(lookup_addr), .grant(grant), .tbl_en(tbl_en), .tbl_we(tbl_we),
    .tbl_addr(tbl_addr), .tbl_wdata(tbl_wdata));

  btb_preload i_preload (
    .clk_i(clk_i), .rst_i(rst_i), .init_valid(init_valid), .init_addr(init_addr),
    .init_entry(init_entry), .grant(grant), .req(preload_req), .we(preload_we),
    .addr(preload_addr), .wdata(preload_wdata), .preload_busy(preload_busy));

  btb_update i_update (
    .clk_i(clk_i), .rst_i(rst_i), .resolve_valid(resolve_valid), .mem_pc(mem_pc),
    .resolve_taken(resolve_taken), .resolve_target(resolve_target),
    .pred_taken(pred_taken_in), .pred_target(pred_target_in), .grant(grant),
    .rdata(tbl_rdata), .req(update_req), .we(update_we), .addr(update_addr),
    .wdata(update_wdata), .update_busy(update_busy), .redirect_valid(redirect_valid),
    .redirect_pc(redirect_pc));

  btb_fetch_predict i_fetch (
    .clk_i(clk_i), .rst_i(rst_i), .fetch_valid(fetch_valid), .pc(pc),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .grant(grant),
    .rdata(tbl_rdata), .req(lookup_req), .addr(lookup_addr), .fetch_stall(fetch_stall),
    .pred_valid(pred_valid), .hit(hit), .pred_taken(pred_taken), .next_pc(next_pc));

endmodule

/* hw/btb_fetch_predict.sv */
/* fetch side lookup
   reads the entry for pc, compares the tag and picks the next pc */

`timescale 1ns/10ps

module btb_fetch_predict (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        fetch_valid,     // level, pc held while stalled
  input  logic [bp_pkg::pc_w-1:0]     pc,
  input  logic                        redirect_valid,
  input  logic [bp_pkg::pc_w-1:0]     redirect_pc,
  input  bp_pkg::grant_e              grant,
  input  logic [bp_pkg::entry_w-1:0]  rdata,
  output logic                        req,
  output logic [bp_pkg::index_w-1:0]  addr,
  output logic                        fetch_stall,
  output logic                        pred_valid,
  output logic                        hit,
  output logic                        pred_taken,
  output logic [bp_pkg::pc_w-1:0]     next_pc
);

  logic                        granted;
  logic [bp_pkg::pc_w-1:0]     lk_pc;          // pc of the read in flight
  logic                        dir_taken;      // counter says taken
  bp_pkg::ctr_e                rd_ctr;
  logic [bp_pkg::target_w-1:0] rd_target;

  assign req         = fetch_valid;
  assign addr        = pc[bp_pkg::index_w+1:2];
  assign granted     = (grant == bp_pkg::grant_lookup);
  assign fetch_stall = fetch_valid && !granted;          // lost the port this cycle

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pred_valid <= 1'b0;
    end else begin
      pred_valid <= fetch_valid && granted;              // result next cycle
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid && granted) begin
      lk_pc <= pc;
    end
  end

  assign rd_ctr    = bp_pkg::ctr_e'(rdata[1:0]);
  assign rd_target = rdata[bp_pkg::target_lsb +: bp_pkg::target_w];
  assign dir_taken = (rd_ctr == bp_pkg::ctr_weak_t) || (rd_ctr == bp_pkg::ctr_strong_t);

  // hit only in the result cycle
  assign hit = pred_valid && rdata[bp_pkg::valid_bit] &&
               (rdata[bp_pkg::tag_lsb +: bp_pkg::tag_w] == lk_pc[bp_pkg::pc_w-1 -: bp_pkg::tag_w]);

  assign pred_taken = hit && dir_taken && !redirect_valid;   // redirect overrides

  always_comb begin
    if (redirect_valid) begin
      next_pc = redirect_pc;                             // mispredict recovery first
    end else if (pred_taken) begin
      next_pc = {rd_target, 2'b00};
    end else begin
      next_pc = lk_pc + 32'd4;                           // fall through
    end
  end

endmodule

/* hw/btb_update.sv */
/* resolved branch updater
   read, decide, write on the table entry plus mispredict redirect */

`timescale 1ns/10ps

module btb_update (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        resolve_valid,   // one cycle strobe from mem stage
  input  logic [bp_pkg::pc_w-1:0]     mem_pc,
  input  logic                        resolve_taken,
  input  logic [bp_pkg::pc_w-1:0]     resolve_target,
  input  logic                        pred_taken,      // prediction carried down the pipe
  input  logic [bp_pkg::pc_w-1:0]     pred_target,
  input  bp_pkg::grant_e              grant,
  input  logic [bp_pkg::entry_w-1:0]  rdata,
  output logic                        req,
  output logic                        we,
  output logic [bp_pkg::index_w-1:0]  addr,
  output logic [bp_pkg::entry_w-1:0]  wdata,
  output logic                        update_busy,
  output logic                        redirect_valid,
  output logic [bp_pkg::pc_w-1:0]     redirect_pc
);

  typedef enum logic [1:0] {st_idle, st_read, st_decide, st_write} state_e;

  state_e                      state;
  logic [bp_pkg::index_w-1:0]  r_idx;       // captured resolve fields
  logic [bp_pkg::tag_w-1:0]    r_tag;
  logic [bp_pkg::target_w-1:0] r_target;
  logic                        r_taken;
  logic [bp_pkg::entry_w-1:0]  wr_entry;    // entry to write back
  logic [bp_pkg::entry_w-1:0]  new_entry;
  logic                        mispredict;
  logic                        granted;
  logic                        rd_hit;
  logic [bp_pkg::target_w-1:0] rd_target;
  bp_pkg::ctr_e                rd_ctr;

  function automatic bp_pkg::ctr_e ctr_step(input bp_pkg::ctr_e ctr, input logic taken);
    bp_pkg::ctr_e nxt;
    case (ctr)
      bp_pkg::ctr_strong_nt: nxt = taken ? bp_pkg::ctr_weak_nt  : bp_pkg::ctr_strong_nt;
      bp_pkg::ctr_weak_nt:   nxt = taken ? bp_pkg::ctr_weak_t   : bp_pkg::ctr_strong_nt;
      bp_pkg::ctr_weak_t:    nxt = taken ? bp_pkg::ctr_strong_t : bp_pkg::ctr_weak_nt;
      default:               nxt = taken ? bp_pkg::ctr_strong_t : bp_pkg::ctr_weak_t;
    endcase
    return nxt;
  endfunction

  assign granted    = (grant == bp_pkg::grant_update);
  assign mispredict = (resolve_taken != pred_taken) ||
                      (resolve_taken && (resolve_target != pred_target));

  // entry fields, valid in st_decide
  assign rd_hit    = rdata[bp_pkg::valid_bit] &&
                     (rdata[bp_pkg::tag_lsb +: bp_pkg::tag_w] == r_tag);
  assign rd_target = rdata[bp_pkg::target_lsb +: bp_pkg::target_w];
  assign rd_ctr    = bp_pkg::ctr_e'(rdata[1:0]);

  always_comb begin
    if (rd_hit) begin
      new_entry = {1'b1, r_tag, (r_taken ? r_target : rd_target), ctr_step(rd_ctr, r_taken)};
    end else begin
      new_entry = {1'b1, r_tag, r_target, bp_pkg::ctr_weak_t};   // allocate on taken miss
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state          <= st_idle;
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= resolve_valid && mispredict;   // exactly one cycle after strobe
      case (state)
        st_idle:   if (resolve_valid) state <= st_read;
        st_read:   if (granted) state <= st_decide;
        st_decide: state <= (rd_hit || r_taken) ? st_write : st_idle;  // skip not-taken miss
        st_write:  if (granted) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (resolve_valid && (state == st_idle)) begin
      r_idx    <= mem_pc[bp_pkg::index_w+1:2];
      r_tag    <= mem_pc[bp_pkg::pc_w-1 -: bp_pkg::tag_w];
      r_target <= resolve_target[bp_pkg::pc_w-1:2];
      r_taken  <= resolve_taken;
    end
    if (resolve_valid) begin
      redirect_pc <= resolve_taken ? resolve_target : mem_pc + 32'd4;
    end
    if (state == st_decide) begin
      wr_entry <= new_entry;
    end
  end

  assign req         = (state == st_read) || (state == st_write);
  assign we          = (state == st_write);
  assign addr        = r_idx;
  assign wdata       = wr_entry;
  assign update_busy = (state != st_idle);

endmodule

/* hw/btb_preload.sv */
/* table preload sequencer
   clears every entry after reset, then takes external preload writes */

`timescale 1ns/10ps

module btb_preload (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        init_valid,    // one write request, strobe
  input  logic [bp_pkg::index_w-1:0]  init_addr,
  input  logic [bp_pkg::entry_w-1:0]  init_entry,
  input  bp_pkg::grant_e              grant,
  output logic                        req,
  output logic                        we,
  output logic [bp_pkg::index_w-1:0]  addr,
  output logic [bp_pkg::entry_w-1:0]  wdata,
  output logic                        preload_busy   // high until sweep is done
);

  logic [bp_pkg::index_w-1:0] sweep_cnt;             // next entry to clear
  logic                       pend;                  // init write waiting for port
  logic [bp_pkg::index_w-1:0] pend_addr;
  logic [bp_pkg::entry_w-1:0] pend_entry;
  logic                       granted;

  assign granted = (grant == bp_pkg::grant_preload);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      preload_busy <= 1'b1;
      sweep_cnt    <= '0;
      pend         <= 1'b0;
    end else begin
      if (preload_busy && granted) begin
        sweep_cnt <= sweep_cnt + 1'b1;
        if (sweep_cnt == bp_pkg::index_w'(bp_pkg::btb_entries - 1)) begin
          preload_busy <= 1'b0;                      // last entry cleared
        end
      end
      if (init_valid && !preload_busy) begin
        pend <= 1'b1;                                // newest request wins
      end else if (pend && granted && !preload_busy) begin
        pend <= 1'b0;
      end
    end
  end

  // buffered write payload
  always_ff @(posedge clk_i) begin
    if (init_valid && !preload_busy) begin
      pend_addr  <= init_addr;
      pend_entry <= init_entry;
    end
  end

  assign req   = preload_busy || pend;               // preload only ever writes
  assign we    = req;
  assign addr  = preload_busy ? sweep_cnt : pend_addr;
  assign wdata = preload_busy ? '0 : pend_entry;     // sweep writes invalid entries

endmodule

/* hw/btb_arbiter.sv */
/* table port arbiter
   fixed priority preload > update > lookup, muxes address and write data */

`timescale 1ns/10ps

module btb_arbiter (
  input  logic                        preload_req,
  input  logic                        preload_we,
  input  logic [bp_pkg::index_w-1:0]  preload_addr,
  input  logic [bp_pkg::entry_w-1:0]  preload_wdata,
  input  logic                        update_req,
  input  logic                        update_we,
  input  logic [bp_pkg::index_w-1:0]  update_addr,
  input  logic [bp_pkg::entry_w-1:0]  update_wdata,
  input  logic                        lookup_req,
  input  logic [bp_pkg::index_w-1:0]  lookup_addr,
  output bp_pkg::grant_e              grant,
  output logic                        tbl_en,
  output logic                        tbl_we,
  output logic [bp_pkg::index_w-1:0]  tbl_addr,
  output logic [bp_pkg::entry_w-1:0]  tbl_wdata
);

  // grant is combinational, losers hold their request into next cycle
  always_comb begin
    if (preload_req) begin
      grant = bp_pkg::grant_preload;
    end else if (update_req) begin
      grant = bp_pkg::grant_update;
    end else if (lookup_req) begin
      grant = bp_pkg::grant_lookup;
    end else begin
      grant = bp_pkg::grant_none;
    end
  end

  assign tbl_en = (grant != bp_pkg::grant_none);   // port idle without a winner

  always_comb begin
    tbl_we    = 1'b0;
    tbl_addr  = lookup_addr;                        // lookup is the default path
    tbl_wdata = '0;
    case (grant)
      bp_pkg::grant_preload: begin
        tbl_we    = preload_we;
        tbl_addr  = preload_addr;
        tbl_wdata = preload_wdata;
      end
      bp_pkg::grant_update: begin
        tbl_we    = update_we;
        tbl_addr  = update_addr;
        tbl_wdata = update_wdata;
      end
      default: begin
        tbl_we    = 1'b0;                           // lookup only reads
      end
    endcase
  end

endmodule

/* hw/btb_table.sv */
/* btb entry storage
   single port, one access per cycle, read data registered */

`timescale 1ns/10ps

module btb_table (
  input  logic                        clk_i,
  input  logic                        en,      // access strobe from arbiter
  input  logic                        we,      // write when set, read otherwise
  input  logic [bp_pkg::index_w-1:0]  addr,
  input  logic [bp_pkg::entry_w-1:0]  wdata,
  output logic [bp_pkg::entry_w-1:0]  rdata    // valid one cycle after a read
);

  logic [bp_pkg::entry_w-1:0] mem [bp_pkg::btb_entries];  // the only entry storage

  always_ff @(posedge clk_i) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;           // write, rdata keeps last read
      end else begin
        rdata <= mem[addr];           // registered read
      end
    end
  end

endmodule

/* hw/bp_pkg.sv */
/* branch predictor package
   table geometry, entry field positions, counter and grant encodings */

package bp_pkg;

  localparam int pc_w        = 32;                    // architectural pc width
  localparam int btb_entries = 256;                   // table depth
  localparam int index_w     = 8;                     // index from pc[9:2]
  localparam int tag_w       = 22;                    // tag from pc[31:10]
  localparam int target_w    = 30;                    // word aligned target, low bits dropped
  localparam int entry_w     = 55;                    // valid + tag + target + counter

  // entry field positions, msb first
  localparam int valid_bit   = entry_w - 1;           // bit 54
  localparam int tag_lsb     = 2 + target_w;          // tag occupies 53..32
  localparam int target_lsb  = 2;                     // target occupies 31..2

  // 2-bit saturating direction counter
  typedef enum logic [1:0] {
    ctr_strong_nt = 2'b00,
    ctr_weak_nt   = 2'b01,
    ctr_weak_t    = 2'b10,
    ctr_strong_t  = 2'b11
  } ctr_e;

  // owner of the table port in the current cycle
  typedef enum logic [1:0] {
    grant_none    = 2'b00,
    grant_preload = 2'b01,
    grant_update  = 2'b10,
    grant_lookup  = 2'b11
  } grant_e;

endpackage
